// File: hdl/lcd_stopwatch_pkg.sv
package lcd_stopwatch_pkg;

	typedef logic [3:0] nibble_t;   // lcd data bus, 4-bit mode
	typedef logic [7:0] lcd_byte_t; // command or character
	typedef logic [3:0] bcd_t;

	//////////////////////////////
	// time digits, tenths first
	localparam int digit_count = 5;
	localparam int digit_modulus [digit_count] = '{10, 10, 6, 10, 6};

	//////////////////////////////
	// lcd command codes
	localparam lcd_byte_t cmd_function_set = 8'h28; // 4-bit bus, 2 lines, 5x8
	localparam lcd_byte_t cmd_entry_mode   = 8'h06; // increment, no shift
	localparam lcd_byte_t cmd_display_on   = 8'h0c; // cursor and blink off
	localparam lcd_byte_t cmd_clear        = 8'h01;
	localparam lcd_byte_t cmd_line1_addr   = 8'h80;
	localparam lcd_byte_t cmd_line2_addr   = 8'hc0;

	localparam lcd_byte_t ascii_zero  = 8'h30;
	localparam lcd_byte_t ascii_colon = 8'h3a;

	//////////////////////////////
	// state machines
	typedef enum logic [3:0] {
		INIT_POWER_WAIT, INIT_PULSE_1, INIT_WAIT_1,
		INIT_PULSE_2, INIT_WAIT_2, INIT_PULSE_3,
		INIT_WAIT_3, INIT_PULSE_4, INIT_WAIT_4, INIT_DONE
	} init_state_t;

	typedef enum logic [3:0] {
		DISP_WAIT_INIT, DISP_FUNCTION_SET, DISP_ENTRY_MODE,
		DISP_DISPLAY_ON, DISP_CLEAR, DISP_CLEAR_WAIT,
		DISP_LINE1_ADDR, DISP_LINE1_TEXT, DISP_LINE2_ADDR, DISP_LINE2_TEXT
	} disp_state_t;

	typedef enum logic [2:0] {
		WR_IDLE, WR_UPPER_SETUP, WR_UPPER_PULSE, WR_NIBBLE_GAP,
		WR_LOWER_SETUP, WR_LOWER_PULSE, WR_CMD_GAP
	} wr_state_t;

endpackage

// File: hdl/tenths_tick.sv
`timescale 1ns/100ps

module tenths_tick #(
	parameter int TICK_CYCLES = 5000000 // 100 ms at 50 MHz
) (
	input  logic clock,
	input  logic reset,
	output logic tick
);

	localparam int CNT_W = $clog2(TICK_CYCLES + 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clock) begin
		if (reset) begin
			cnt  <= CNT_W'(TICK_CYCLES - 1);
			tick <= 1'b0;
		end else begin
			tick <= (cnt == '0); // registered strobe
			if (cnt == '0)
				cnt <= CNT_W'(TICK_CYCLES - 1);
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

// File: hdl/bcd_digit.sv
`timescale 1ns/100ps

module bcd_digit #(
	parameter int MODULUS = 10
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    restart,
	input  logic                    carry_in,
	output lcd_stopwatch_pkg::bcd_t digit,
	output logic                    carry_out
);

	logic at_max;

	assign at_max    = (digit == lcd_stopwatch_pkg::bcd_t'(MODULUS - 1));
	assign carry_out = carry_in && at_max; // wraps on this carry

	always_ff @(posedge clock) begin
		if (reset || restart) begin // restart beats the carry
			digit <= '0;
		end else if (carry_in) begin
			if (at_max)
				digit <= '0;
			else
				digit <= digit + 1'b1;
		end
	end

endmodule

// File: hdl/lcd_power_on_init.sv
`timescale 1ns/100ps

module lcd_power_on_init #(
	parameter int POWER_ON_CYCLES = 750000, // 15 ms
	parameter int GAP1_CYCLES     = 205000, // 4.1 ms
	parameter int GAP2_CYCLES     = 5000,   // 100 us
	parameter int GAP3_CYCLES     = 2000,   // 40 us
	parameter int PULSE_CYCLES    = 12
) (
	input  logic                       clock,
	input  logic                       reset,
	output lcd_stopwatch_pkg::nibble_t init_nibble,
	output logic                       init_enable,
	output logic                       init_done
);

	// wide enough for the longest single delay
	localparam int CNT_W = $clog2(POWER_ON_CYCLES + GAP1_CYCLES + GAP2_CYCLES
		+ GAP3_CYCLES + PULSE_CYCLES + 1);

	lcd_stopwatch_pkg::init_state_t state;
	lcd_stopwatch_pkg::init_state_t next_state;
	logic [CNT_W-1:0]               cnt;
	logic [CNT_W-1:0]               next_cnt;

	// successor of each state and its length
	always_comb begin
		next_state = state;
		next_cnt   = '0;
		case (state)
			lcd_stopwatch_pkg::INIT_POWER_WAIT: begin
				next_state = lcd_stopwatch_pkg::INIT_PULSE_1;
				next_cnt   = CNT_W'(PULSE_CYCLES - 1);
			end
			lcd_stopwatch_pkg::INIT_PULSE_1: begin
				next_state = lcd_stopwatch_pkg::INIT_WAIT_1;
				next_cnt   = CNT_W'(GAP1_CYCLES - 1);
			end
			lcd_stopwatch_pkg::INIT_WAIT_1: begin
				next_state = lcd_stopwatch_pkg::INIT_PULSE_2;
				next_cnt   = CNT_W'(PULSE_CYCLES - 1);
			end
			lcd_stopwatch_pkg::INIT_PULSE_2: begin
				next_state = lcd_stopwatch_pkg::INIT_WAIT_2;
				next_cnt   = CNT_W'(GAP2_CYCLES - 1);
			end
			lcd_stopwatch_pkg::INIT_WAIT_2: begin
				next_state = lcd_stopwatch_pkg::INIT_PULSE_3;
				next_cnt   = CNT_W'(PULSE_CYCLES - 1);
			end
			lcd_stopwatch_pkg::INIT_PULSE_3: begin
				next_state = lcd_stopwatch_pkg::INIT_WAIT_3;
				next_cnt   = CNT_W'(GAP3_CYCLES - 1);
			end
			lcd_stopwatch_pkg::INIT_WAIT_3: begin
				next_state = lcd_stopwatch_pkg::INIT_PULSE_4;
				next_cnt   = CNT_W'(PULSE_CYCLES - 1);
			end
			lcd_stopwatch_pkg::INIT_PULSE_4: begin
				next_state = lcd_stopwatch_pkg::INIT_WAIT_4;
				next_cnt   = CNT_W'(GAP3_CYCLES - 1); // last wait before done
			end
			default: begin
				next_state = lcd_stopwatch_pkg::INIT_DONE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= lcd_stopwatch_pkg::INIT_POWER_WAIT;
			cnt         <= CNT_W'(POWER_ON_CYCLES - 1);
			init_nibble <= '0;
		end else begin
			if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				state <= next_state;
				cnt   <= next_cnt;
			end
			// nibble loads one cycle into each wait, giving hold and setup
			case (state)
				lcd_stopwatch_pkg::INIT_POWER_WAIT,
				lcd_stopwatch_pkg::INIT_WAIT_1,
				lcd_stopwatch_pkg::INIT_WAIT_2: init_nibble <= 4'h3;
				lcd_stopwatch_pkg::INIT_WAIT_3: init_nibble <= 4'h2;
				lcd_stopwatch_pkg::INIT_WAIT_4: init_nibble <= 4'h0;
				default:                        init_nibble <= init_nibble;
			endcase
		end
	end

	assign init_enable = (state == lcd_stopwatch_pkg::INIT_PULSE_1)
		|| (state == lcd_stopwatch_pkg::INIT_PULSE_2)
		|| (state == lcd_stopwatch_pkg::INIT_PULSE_3)
		|| (state == lcd_stopwatch_pkg::INIT_PULSE_4);

	assign init_done = (state == lcd_stopwatch_pkg::INIT_DONE); // stays high

endmodule

// File: hdl/lcd_nibble_writer.sv
`timescale 1ns/100ps

module lcd_nibble_writer #(
	parameter int PULSE_CYCLES      = 12,  // e high, 240 ns
	parameter int NIBBLE_GAP_CYCLES = 50,  // 1 us
	parameter int CMD_GAP_CYCLES    = 2000 // 40 us
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         send,
	input  logic                         tx_rs,
	input  lcd_stopwatch_pkg::lcd_byte_t tx_byte,
	input  lcd_stopwatch_pkg::nibble_t   init_nibble,
	input  logic                         init_enable,
	input  logic                         init_done,
	output logic                         done,
	output lcd_stopwatch_pkg::nibble_t   lcd_data,
	output logic                         lcd_e,
	output logic                         lcd_rs
);

	localparam int CNT_W = $clog2(PULSE_CYCLES + NIBBLE_GAP_CYCLES + CMD_GAP_CYCLES + 2);

	lcd_stopwatch_pkg::wr_state_t state;
	lcd_stopwatch_pkg::wr_state_t next_state;
	logic [CNT_W-1:0]             cnt;
	logic [CNT_W-1:0]             next_cnt;
	logic                         rs_q;
	logic                         pulse;
	lcd_stopwatch_pkg::nibble_t   nibble;

	always_comb begin
		next_cnt = '0;
		case (state)
			lcd_stopwatch_pkg::WR_UPPER_SETUP: begin
				next_state = lcd_stopwatch_pkg::WR_UPPER_PULSE;
				next_cnt   = CNT_W'(PULSE_CYCLES - 1);
			end
			lcd_stopwatch_pkg::WR_UPPER_PULSE: begin
				next_state = lcd_stopwatch_pkg::WR_NIBBLE_GAP;
				next_cnt   = CNT_W'(NIBBLE_GAP_CYCLES - 1);
			end
			lcd_stopwatch_pkg::WR_NIBBLE_GAP: begin
				next_state = lcd_stopwatch_pkg::WR_LOWER_SETUP;
				next_cnt   = CNT_W'(1); // 2-cycle setup
			end
			lcd_stopwatch_pkg::WR_LOWER_SETUP: begin
				next_state = lcd_stopwatch_pkg::WR_LOWER_PULSE;
				next_cnt   = CNT_W'(PULSE_CYCLES - 1);
			end
			lcd_stopwatch_pkg::WR_LOWER_PULSE: begin
				next_state = lcd_stopwatch_pkg::WR_CMD_GAP;
				next_cnt   = CNT_W'(CMD_GAP_CYCLES - 1);
			end
			default: begin
				next_state = lcd_stopwatch_pkg::WR_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lcd_stopwatch_pkg::WR_IDLE;
			cnt   <= '0;
			rs_q  <= 1'b0;
		end else if (state == lcd_stopwatch_pkg::WR_IDLE) begin
			if (send) begin
				state <= lcd_stopwatch_pkg::WR_UPPER_SETUP;
				cnt   <= CNT_W'(1);
				rs_q  <= tx_rs; // held for the whole byte
			end
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else begin
			state <= next_state;
			cnt   <= next_cnt;
		end
	end

	assign done = (state == lcd_stopwatch_pkg::WR_CMD_GAP) && (cnt == '0);

	assign pulse = (state == lcd_stopwatch_pkg::WR_UPPER_PULSE)
		|| (state == lcd_stopwatch_pkg::WR_LOWER_PULSE);

	// each nibble stays on the bus through the gap after its pulse
	assign nibble = (state inside {lcd_stopwatch_pkg::WR_UPPER_SETUP,
		lcd_stopwatch_pkg::WR_UPPER_PULSE, lcd_stopwatch_pkg::WR_NIBBLE_GAP})
		? tx_byte[7:4] : tx_byte[3:0];

	//////////////////////////////
	// bus select and output register
	always_ff @(posedge clock) begin
		if (reset) begin
			lcd_data <= '0;
			lcd_e    <= 1'b0;
			lcd_rs   <= 1'b0;
		end else if (!init_done) begin
			lcd_data <= init_nibble;
			lcd_e    <= init_enable;
			lcd_rs   <= 1'b0; // init nibbles are commands
		end else begin
			lcd_data <= nibble;
			lcd_e    <= pulse;
			lcd_rs   <= rs_q;
		end
	end

endmodule

// File: hdl/lcd_display_sequencer.sv
`timescale 1ns/100ps

module lcd_display_sequencer #(
	parameter int CLEAR_CYCLES = 82000 // 1.64 ms
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         init_done,
	input  logic                         done,
	input  lcd_stopwatch_pkg::bcd_t [lcd_stopwatch_pkg::digit_count-1:0] digits,
	output logic                         send,
	output lcd_stopwatch_pkg::lcd_byte_t tx_byte,
	output logic                         tx_rs
);

	localparam int CNT_W     = $clog2(CLEAR_CYCLES + 1);
	localparam int LINE1_LEN = 9;
	localparam int LINE2_LEN = 12; // Time:MM:SS:T
	localparam logic [8*LINE1_LEN-1:0] LINE1_TEXT  = "Stopwatch";
	localparam logic [8*5-1:0]         LINE2_LABEL = "Time:";

	lcd_stopwatch_pkg::disp_state_t state;
	logic [3:0]                     char_idx;
	logic                           busy;   // byte in flight
	logic [CNT_W-1:0]               clear_cnt;
	lcd_stopwatch_pkg::bcd_t [lcd_stopwatch_pkg::digit_count-1:0] shown;
	lcd_stopwatch_pkg::lcd_byte_t   line1_char;
	lcd_stopwatch_pkg::lcd_byte_t   line2_char;

	function automatic lcd_stopwatch_pkg::lcd_byte_t to_ascii(
		input lcd_stopwatch_pkg::bcd_t d
	);
		return lcd_stopwatch_pkg::ascii_zero + {4'h0, d};
	endfunction

	//////////////////////////////
	// text
	assign line1_char = LINE1_TEXT[8*(LINE1_LEN - 1 - char_idx) +: 8];

	always_comb begin
		case (char_idx)
			4'd5:        line2_char = to_ascii(shown[4]); // minutes tens
			4'd6:        line2_char = to_ascii(shown[3]);
			4'd8:        line2_char = to_ascii(shown[2]); // seconds tens
			4'd9:        line2_char = to_ascii(shown[1]);
			4'd11:       line2_char = to_ascii(shown[0]); // tenths
			4'd7, 4'd10: line2_char = lcd_stopwatch_pkg::ascii_colon;
			default:     line2_char = LINE2_LABEL[8*(4 - char_idx) +: 8];
		endcase
	end

	always_comb begin
		case (state)
			lcd_stopwatch_pkg::DISP_FUNCTION_SET: tx_byte = lcd_stopwatch_pkg::cmd_function_set;
			lcd_stopwatch_pkg::DISP_ENTRY_MODE:   tx_byte = lcd_stopwatch_pkg::cmd_entry_mode;
			lcd_stopwatch_pkg::DISP_DISPLAY_ON:   tx_byte = lcd_stopwatch_pkg::cmd_display_on;
			lcd_stopwatch_pkg::DISP_CLEAR:        tx_byte = lcd_stopwatch_pkg::cmd_clear;
			lcd_stopwatch_pkg::DISP_LINE1_ADDR:   tx_byte = lcd_stopwatch_pkg::cmd_line1_addr;
			lcd_stopwatch_pkg::DISP_LINE1_TEXT:   tx_byte = line1_char;
			lcd_stopwatch_pkg::DISP_LINE2_ADDR:   tx_byte = lcd_stopwatch_pkg::cmd_line2_addr;
			lcd_stopwatch_pkg::DISP_LINE2_TEXT:   tx_byte = line2_char;
			default:                              tx_byte = '0;
		endcase
	end

	assign tx_rs = (state == lcd_stopwatch_pkg::DISP_LINE1_TEXT)
		|| (state == lcd_stopwatch_pkg::DISP_LINE2_TEXT);

	// one strobe per byte, next one only after done
	assign send = !busy && !(state inside {lcd_stopwatch_pkg::DISP_WAIT_INIT,
		lcd_stopwatch_pkg::DISP_CLEAR_WAIT});

	//////////////////////////////
	// sequencer
	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= lcd_stopwatch_pkg::DISP_WAIT_INIT;
			busy      <= 1'b0;
			char_idx  <= '0;
			clear_cnt <= '0;
		end else begin
			if (done)
				busy <= 1'b0;
			else if (send)
				busy <= 1'b1;
			case (state)
				lcd_stopwatch_pkg::DISP_WAIT_INIT:
					if (init_done) state <= lcd_stopwatch_pkg::DISP_FUNCTION_SET;
				lcd_stopwatch_pkg::DISP_FUNCTION_SET:
					if (done) state <= lcd_stopwatch_pkg::DISP_ENTRY_MODE;
				lcd_stopwatch_pkg::DISP_ENTRY_MODE:
					if (done) state <= lcd_stopwatch_pkg::DISP_DISPLAY_ON;
				lcd_stopwatch_pkg::DISP_DISPLAY_ON:
					if (done) state <= lcd_stopwatch_pkg::DISP_CLEAR;
				lcd_stopwatch_pkg::DISP_CLEAR:
					if (done) begin
						state     <= lcd_stopwatch_pkg::DISP_CLEAR_WAIT;
						clear_cnt <= CNT_W'(CLEAR_CYCLES - 1);
					end
				lcd_stopwatch_pkg::DISP_CLEAR_WAIT:
					if (clear_cnt != '0)
						clear_cnt <= clear_cnt - 1'b1;
					else
						state <= lcd_stopwatch_pkg::DISP_LINE1_ADDR;
				lcd_stopwatch_pkg::DISP_LINE1_ADDR:
					if (done) begin
						state    <= lcd_stopwatch_pkg::DISP_LINE1_TEXT;
						char_idx <= '0;
					end
				lcd_stopwatch_pkg::DISP_LINE1_TEXT:
					if (done) begin
						if (char_idx == 4'(LINE1_LEN - 1))
							state <= lcd_stopwatch_pkg::DISP_LINE2_ADDR;
						else
							char_idx <= char_idx + 1'b1;
					end
				lcd_stopwatch_pkg::DISP_LINE2_ADDR:
					if (done) begin
						state    <= lcd_stopwatch_pkg::DISP_LINE2_TEXT;
						char_idx <= '0;
					end
				lcd_stopwatch_pkg::DISP_LINE2_TEXT:
					if (done) begin
						if (char_idx == 4'(LINE2_LEN - 1))
							state <= lcd_stopwatch_pkg::DISP_LINE2_ADDR; // next frame
						else
							char_idx <= char_idx + 1'b1;
					end
				default: state <= lcd_stopwatch_pkg::DISP_WAIT_INIT;
			endcase
		end
	end

	// snapshot per frame so the time shown is consistent
	always_ff @(posedge clock) begin
		if (send && state == lcd_stopwatch_pkg::DISP_LINE2_ADDR)
			shown <= digits;
	end

endmodule

// File: hdl/lcd_stopwatch.sv
`timescale 1ns/100ps

module lcd_stopwatch #(
	parameter int TICK_CYCLES       = 5000000,
	parameter int POWER_ON_CYCLES   = 750000,
	parameter int GAP1_CYCLES       = 205000,
	parameter int GAP2_CYCLES       = 5000,
	parameter int GAP3_CYCLES       = 2000,
	parameter int PULSE_CYCLES      = 12,
	parameter int NIBBLE_GAP_CYCLES = 50,
	parameter int CMD_GAP_CYCLES    = 2000,
	parameter int CLEAR_CYCLES      = 82000
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       restart,
	output lcd_stopwatch_pkg::nibble_t lcd_data,
	output logic                       lcd_e,
	output logic                       lcd_rs
);

	logic                                                      tick;
	logic [lcd_stopwatch_pkg::digit_count:0]                   carry;
	lcd_stopwatch_pkg::bcd_t [lcd_stopwatch_pkg::digit_count-1:0] digits;
	lcd_stopwatch_pkg::nibble_t                                init_nibble;
	logic                                                      init_enable;
	logic                                                      init_done;
	logic                                                      send;
	logic                                                      done;
	logic                                                      tx_rs;
	lcd_stopwatch_pkg::lcd_byte_t                              tx_byte;

	tenths_tick #(.TICK_CYCLES(TICK_CYCLES)) u_tick (
		.clock(clock),
		.reset(reset),
		.tick (tick)
	);

	//////////////////////////////
	// digit chain, tenths first
	assign carry[0] = tick;

	for (genvar i = 0; i < lcd_stopwatch_pkg::digit_count; i++) begin : g_digit
		bcd_digit #(.MODULUS(lcd_stopwatch_pkg::digit_modulus[i])) u_digit (
			.clock    (clock),
			.reset    (reset),
			.restart  (restart),
			.carry_in (carry[i]),
			.digit    (digits[i]),
			.carry_out(carry[i+1])
		);
	end

	//////////////////////////////
	// lcd side
	lcd_power_on_init #(
		.POWER_ON_CYCLES(POWER_ON_CYCLES),
		.GAP1_CYCLES    (GAP1_CYCLES),
		.GAP2_CYCLES    (GAP2_CYCLES),
		.GAP3_CYCLES    (GAP3_CYCLES),
		.PULSE_CYCLES   (PULSE_CYCLES)
	) u_init (
		.clock      (clock),
		.reset      (reset),
		.init_nibble(init_nibble),
		.init_enable(init_enable),
		.init_done  (init_done)
	);

	lcd_display_sequencer #(.CLEAR_CYCLES(CLEAR_CYCLES)) u_seq (
		.clock    (clock),
		.reset    (reset),
		.init_done(init_done),
		.done     (done),
		.digits   (digits),
		.send     (send),
		.tx_byte  (tx_byte),
		.tx_rs    (tx_rs)
	);

	lcd_nibble_writer #(
		.PULSE_CYCLES     (PULSE_CYCLES),
		.NIBBLE_GAP_CYCLES(NIBBLE_GAP_CYCLES),
		.CMD_GAP_CYCLES   (CMD_GAP_CYCLES)
	) u_writer (
		.clock      (clock),
		.reset      (reset),
		.send       (send),
		.tx_rs      (tx_rs),
		.tx_byte    (tx_byte),
		.init_nibble(init_nibble),
		.init_enable(init_enable),
		.init_done  (init_done),
		.done       (done),
		.lcd_data   (lcd_data),
		.lcd_e      (lcd_e),
		.lcd_rs     (lcd_rs)
	);

endmodule

// File: tb/lcd_stopwatch_checker.sv
`timescale 1ns/100ps

module lcd_stopwatch_checker (
	input logic                         clock,
	input logic                         reset,
	input logic                         send,
	input logic                         done,
	input lcd_stopwatch_pkg::wr_state_t state,
	input lcd_stopwatch_pkg::nibble_t   lcd_data,
	input logic                         lcd_e,
	input logic                         lcd_rs
);

	logic in_flight; // byte between send and done

	always_ff @(posedge clock) begin
		if (reset)
			in_flight <= 1'b0;
		else if (done)
			in_flight <= 1'b0;
		else if (send)
			in_flight <= 1'b1;
	end

	// bus held while the enable is high
	assert property (@(posedge clock) disable iff (reset)
		lcd_e && $past(lcd_e) |-> $stable(lcd_data) && $stable(lcd_rs))
		else $error("lcd_data or lcd_rs changed while lcd_e was high");

	assert property (@(posedge clock) disable iff (reset)
		$fell(lcd_e) |-> $stable(lcd_data) && $stable(lcd_rs))
		else $error("lcd_data or lcd_rs changed on the falling edge of lcd_e");

	// the writer only takes a new byte from idle
	assert property (@(posedge clock) disable iff (reset)
		send |-> state == lcd_stopwatch_pkg::WR_IDLE)
		else $error("send raised while the writer was still busy with a byte");

	assert property (@(posedge clock) disable iff (reset) done |-> in_flight)
		else $error("done raised with no byte in flight");

endmodule

bind lcd_nibble_writer lcd_stopwatch_checker u_checker (.*);

// File: tb/lcd_stopwatch_tb.sv
`timescale 1ns/100ps

module lcd_stopwatch_tb;

	localparam int TICK_CYCLES       = 4000;
	localparam int POWER_ON_CYCLES   = 40;
	localparam int GAP1_CYCLES       = 20;
	localparam int GAP2_CYCLES       = 10;
	localparam int GAP3_CYCLES       = 8;
	localparam int PULSE_CYCLES      = 3;
	localparam int NIBBLE_GAP_CYCLES = 4;
	localparam int CMD_GAP_CYCLES    = 12;
	localparam int CLEAR_CYCLES      = 30;

	// send to done plus the idle cycle before the next send
	localparam int BYTE_CYCLES  = 2 + PULSE_CYCLES + NIBBLE_GAP_CYCLES + 2 + PULSE_CYCLES
		+ CMD_GAP_CYCLES + 1;
	localparam int FRAME_CYCLES = 13 * BYTE_CYCLES; // address and 12 characters
	localparam int INIT_CYCLES  = POWER_ON_CYCLES + GAP1_CYCLES + GAP2_CYCLES
		+ 2 * GAP3_CYCLES + 4 * PULSE_CYCLES + CLEAR_CYCLES + 15 * BYTE_CYCLES;
	localparam int STALL_CYCLES = 4 * BYTE_CYCLES;
	localparam int MAX_DELAY    = 1500; // random restart start, in cycles

	// restart pulse cycles, frames to check after it, max tenths in the first one
	localparam int ROWS = 4;
	localparam int STIM [ROWS][3] = '{
		'{1, 40, 1},
		'{3, 130, 1},
		'{2, 20, 1},
		'{4, 60, 1}
	};

	localparam logic [7:0] CONFIG_BYTES [5] = '{8'h28, 8'h06, 8'h0c, 8'h01, 8'h80};
	localparam logic [3:0] INIT_NIBBLES [4] = '{4'h3, 4'h3, 4'h3, 4'h2};
	localparam int         DIGIT_POS [5]    = '{5, 6, 8, 9, 11}; // M M S S T

	logic       clock;
	logic       reset;
	logic       restart;
	logic [3:0] lcd_data;
	logic       lcd_e;
	logic       lcd_rs;

	string       line1_text  = "Stopwatch";
	string       line2_label = "Time:";
	int          cycle       = 0;
	logic [31:0] lcg_state   = 32'hed3b;

	// decoded bus items, oldest first
	logic [7:0] rx_data_q [$];
	logic       rx_rs_q [$];
	int         rx_cycle_q [$];

	int   ref_cycle; // where the shown time counts from
	int   prev_value;
	logic prev_valid;

	lcd_stopwatch #(
		.TICK_CYCLES      (TICK_CYCLES),
		.POWER_ON_CYCLES  (POWER_ON_CYCLES),
		.GAP1_CYCLES      (GAP1_CYCLES),
		.GAP2_CYCLES      (GAP2_CYCLES),
		.GAP3_CYCLES      (GAP3_CYCLES),
		.PULSE_CYCLES     (PULSE_CYCLES),
		.NIBBLE_GAP_CYCLES(NIBBLE_GAP_CYCLES),
		.CMD_GAP_CYCLES   (CMD_GAP_CYCLES),
		.CLEAR_CYCLES     (CLEAR_CYCLES)
	) UUT (
		.clock   (clock),
		.reset   (reset),
		.restart (restart),
		.lcd_data(lcd_data),
		.lcd_e   (lcd_e),
		.lcd_rs  (lcd_rs)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	//////////////////////////////
	// checks
	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error: %s is %0h, expected %0h at cycle %0d", name, actual, expected,
				cycle);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s at cycle %0d", msg, cycle);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic next_item(output logic [7:0] data, output logic rs, output int at);
		int waited;
		waited = 0;
		while (rx_data_q.size() == 0) begin
			@(posedge clock);
			waited++;
			if (waited > STALL_CYCLES)
				report_failure("the LCD bus stopped delivering bytes");
		end
		data = rx_data_q.pop_front();
		rs   = rx_rs_q.pop_front();
		at   = rx_cycle_q.pop_front();
	endtask

	task automatic expect_item(input string name, input logic [7:0] expected,
		input logic expected_rs);
		logic [7:0] data;
		logic       rs;
		int         at;
		next_item(data, rs, at);
		check_equal(name, data, expected);
		check_equal("lcd_rs", rs, expected_rs);
	endtask

	// one line-2 frame, value in tenths, at is when its address byte arrived
	task automatic read_frame(output int value, output int at);
		logic [7:0] ch [12];
		logic [7:0] data;
		logic       rs;
		int         d [5];
		int         t;
		int         i;
		next_item(data, rs, at);
		check_equal("line 2 address", data, 8'hc0);
		check_equal("lcd_rs", rs, 1'b0);
		for (i = 0; i < 12; i++) begin
			next_item(ch[i], rs, t);
			check_equal("lcd_rs", rs, 1'b1);
		end
		for (i = 0; i < 5; i++)
			check_equal("line 2 label", ch[i], line2_label[i]);
		check_equal("minutes colon", ch[7], 8'h3a);
		check_equal("seconds colon", ch[10], 8'h3a);
		for (i = 0; i < 5; i++) begin
			if (ch[DIGIT_POS[i]] < 8'h30 || ch[DIGIT_POS[i]] > 8'h39)
				report_failure($sformatf("line 2 char %0d is not a digit", DIGIT_POS[i]));
			d[i] = int'(ch[DIGIT_POS[i]] - 8'h30);
		end
		if (d[0] > 5 || d[2] > 5)
			report_failure("a tens digit of minutes or seconds is above 5");
		value = ((d[0] * 10 + d[1]) * 60 + d[2] * 10 + d[3]) * 10 + d[4];
	endtask

	task automatic check_progress(input int value, input int at);
		int elapsed;
		int low;
		int high;
		elapsed = at - ref_cycle;
		low     = (elapsed - FRAME_CYCLES) / TICK_CYCLES - 1;
		high    = (elapsed + FRAME_CYCLES) / TICK_CYCLES + 1;
		if (value < low || value > high)
			report_failure($sformatf("shown time %0d tenths lies outside %0d..%0d",
				value, low, high));
		if (prev_valid && value < prev_value)
			report_failure($sformatf("shown time fell from %0d to %0d tenths with no restart",
				prev_value, value));
		prev_value = value;
		prev_valid = 1'b1;
	endtask

	//////////////////////////////
	// bus decoder
	logic       prev_e = 1'b0;
	logic [3:0] held_data;
	logic       held_rs;
	logic [3:0] upper_data;
	logic       upper_rs;
	int         nibble_count = 0;

	// mid-cycle sampling, data is held from the pulse through the fall
	always @(negedge clock) begin
		if (prev_e && !lcd_e) begin
			if (nibble_count < 4) begin // init nibbles stand alone
				rx_data_q.push_back({4'h0, held_data});
				rx_rs_q.push_back(held_rs);
				rx_cycle_q.push_back(cycle);
			end else if (nibble_count % 2 == 0) begin
				upper_data = held_data;
				upper_rs   = held_rs;
			end else begin
				check_equal("lcd_rs across nibbles", held_rs, upper_rs);
				rx_data_q.push_back({upper_data, held_data});
				rx_rs_q.push_back(held_rs);
				rx_cycle_q.push_back(cycle);
			end
			nibble_count++;
		end
		if (lcd_e) begin
			held_data = lcd_data;
			held_rs   = lcd_rs;
		end
		prev_e = lcd_e;
	end

	//////////////////////////////
	// watchdog
	initial begin
		int total_frames;
		int limit;
		int r;
		total_frames = 0;
		for (r = 0; r < ROWS; r++)
			total_frames += STIM[r][1];
		limit = INIT_CYCLES + ROWS * (MAX_DELAY + 8) + (total_frames + 8 * ROWS) * FRAME_CYCLES;
		limit = 2 * limit; // margin
		repeat (limit) @(posedge clock);
		$display("run did not finish within %0d cycles", limit);
		$display("Checks failed");
		$fatal(1);
	end

	//////////////////////////////
	// stimulus and sequence checks
	initial begin
		int row;
		int i;
		int delay;
		int start;
		int stop;
		int post;
		int value;
		int at;
		restart    = 1'b0;
		reset      = 1'b1;
		prev_valid = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		ref_cycle = cycle;

		for (i = 0; i < 4; i++)
			expect_item("init nibble", {4'h0, INIT_NIBBLES[i]}, 1'b0);
		for (i = 0; i < 5; i++)
			expect_item("config byte", CONFIG_BYTES[i], 1'b0);
		for (i = 0; i < line1_text.len(); i++)
			expect_item("line 1 char", line1_text[i], 1'b1);

		for (row = 0; row < ROWS; row++) begin
			delay = int'((lcg_next() >> 8) % MAX_DELAY);
			repeat (delay) @(posedge clock);
			restart <= 1'b1;
			start = cycle;
			repeat (STIM[row][0]) @(posedge clock);
			restart <= 1'b0;
			stop = cycle;
			post = 0;
			while (post < STIM[row][1]) begin
				read_frame(value, at);
				if (at < start) begin
					check_progress(value, at); // latched before the restart
				end else if (at > stop + 2 * BYTE_CYCLES) begin
					if (post == 0) begin
						if (value > STIM[row][2])
							report_failure($sformatf("first frame after restart %0d shows %0d tenths",
								row, value));
						ref_cycle  = stop;
						prev_valid = 1'b0;
					end
					check_progress(value, at);
					post++;
				end else begin
					prev_valid = 1'b0; // latched around the restart
				end
			end
		end
		$display("All checks passed");
		$finish;
	end

endmodule

// File: lcd_stopwatch.f
hdl/lcd_stopwatch_pkg.sv
hdl/tenths_tick.sv
hdl/bcd_digit.sv
hdl/lcd_power_on_init.sv
hdl/lcd_nibble_writer.sv
hdl/lcd_display_sequencer.sv
hdl/lcd_stopwatch.sv
tb/lcd_stopwatch_checker.sv
tb/lcd_stopwatch_tb.sv

// File: Makefile
TOP = lcd_stopwatch_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f lcd_stopwatch.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only -Wall --top-module lcd_stopwatch \
		hdl/lcd_stopwatch_pkg.sv hdl/tenths_tick.sv hdl/bcd_digit.sv \
		hdl/lcd_power_on_init.sv hdl/lcd_nibble_writer.sv \
		hdl/lcd_display_sequencer.sv hdl/lcd_stopwatch.sv

clean:
	rm -rf obj_dir
